/* hci_ecc_pkg.sv */
package hci_ecc_pkg;

  // bus geometry, one 32-bit word per beat
  localparam int unsigned HCI_DW   = 32;
  localparam int unsigned HCI_BEW  = HCI_DW / 8;

  // secded (39,32) code geometry
  localparam int unsigned ECC_BITS = 7;
  localparam int unsigned CW_BITS  = HCI_DW + ECC_BITS;

  // error class reported by every checker
  typedef enum logic [1:0] {
    ECC_NONE   = 2'd0,
    ECC_SINGLE = 2'd1,
    ECC_DOUBLE = 2'd2
  } ecc_err_e;

  // builds row `row` of the hsiao check matrix
  // data columns are the first 32 weight-3 patterns of 7 bits, in lexical order
  // check columns are unit vectors, so every column has odd weight and all differ
  function automatic logic [CW_BITS-1:0] hsiao_row(int unsigned row);
    logic [CW_BITS-1:0] mask;
    int unsigned        col;
    mask = '0;
    col  = 0;
    for (int unsigned a = 0; a < ECC_BITS; a++) begin
      for (int unsigned b = a + 1; b < ECC_BITS; b++) begin
        for (int unsigned c = b + 1; c < ECC_BITS; c++) begin
          if (col < HCI_DW) begin
            mask[col] = (row == a) || (row == b) || (row == c);
            col++;
          end
        end
      end
    end
    // check bit `row` covers itself
    mask[HCI_DW + row] = 1'b1;
    return mask;
  endfunction

  // check bit i is the parity of the codeword bits selected by SECDED_H[i]
  localparam logic [CW_BITS-1:0] SECDED_H [ECC_BITS] = '{
    hsiao_row(0), hsiao_row(1), hsiao_row(2), hsiao_row(3),
    hsiao_row(4), hsiao_row(5), hsiao_row(6)
  };

endpackage

/* hci_mem_intf.sv */
`timescale 1ns/1ps

interface hci_mem_intf #(
  parameter int unsigned UW = 4
);

  import hci_ecc_pkg::*;

  // request channel
  logic               req;
  logic               gnt;
  // byte address, word aligned
  logic [HCI_DW-1:0]  add;
  // high for read, low for write
  logic               wen;
  logic [HCI_DW-1:0]  data;
  logic [HCI_BEW-1:0] be;
  // user sideband, ecc rides in the upper bits when present
  logic [UW-1:0]      user;

  // response channel, one cycle after an accepted read
  logic [HCI_DW-1:0]  r_data;
  logic [UW-1:0]      r_user;
  logic               r_valid;

  // side that issues requests
  modport initiator (
    output req, add, wen, data, be, user,
    input  gnt, r_data, r_user, r_valid
  );

  // side that serves requests
  modport target (
    input  req, add, wen, data, be, user,
    output gnt, r_data, r_user, r_valid
  );

endinterface

/* secded_39_32_enc.sv */
`timescale 1ns/1ps

module secded_39_32_enc (
  input  logic [hci_ecc_pkg::HCI_DW-1:0]  data_i,
  output logic [hci_ecc_pkg::CW_BITS-1:0] code_o
);

  import hci_ecc_pkg::*;

  logic [CW_BITS-1:0]  data_ext;
  logic [ECC_BITS-1:0] check;

  // check bits are zero while they are being computed
  assign data_ext = {{ECC_BITS{1'b0}}, data_i};

  // one parity tree per row of the matrix
  always_comb begin
    for (int unsigned i = 0; i < ECC_BITS; i++) begin
      check[i] = ^(data_ext & SECDED_H[i]);
    end
  end

  // systematic code, data in the low bits and check bits on top
  assign code_o = {check, data_i};

endmodule

/* secded_39_32_dec.sv */
`timescale 1ns/1ps

module secded_39_32_dec (
  input  logic [hci_ecc_pkg::CW_BITS-1:0]  code_i,
  output logic [hci_ecc_pkg::HCI_DW-1:0]   data_o,
  output logic [hci_ecc_pkg::ECC_BITS-1:0] syndrome_o,
  output hci_ecc_pkg::ecc_err_e            err_o
);

  import hci_ecc_pkg::*;

  logic [ECC_BITS-1:0] syndrome;
  logic [HCI_DW-1:0]   data_fix;

  // column j of the check matrix
  function automatic logic [ECC_BITS-1:0] h_col(int unsigned j);
    logic [ECC_BITS-1:0] col;
    for (int unsigned i = 0; i < ECC_BITS; i++) begin
      col[i] = SECDED_H[i][j];
    end
    return col;
  endfunction

  // recompute parity over the full codeword
  // a clean word gives an all-zero syndrome
  always_comb begin
    for (int unsigned i = 0; i < ECC_BITS; i++) begin
      syndrome[i] = ^(code_i & SECDED_H[i]);
    end
  end

  // odd weight points at one flipped bit
  // only data columns need fixing, check bit errors are reported and dropped
  always_comb begin
    data_fix = code_i[HCI_DW-1:0];
    if (^syndrome) begin
      for (int unsigned j = 0; j < HCI_DW; j++) begin
        if (h_col(j) == syndrome) begin
          data_fix[j] = ~code_i[j];
        end
      end
    end
  end

  // classify by syndrome weight
  always_comb begin
    if (syndrome == '0) begin
      err_o = ECC_NONE;
    end else if (^syndrome) begin
      err_o = ECC_SINGLE;
    end else begin
      // even and non-zero, two columns cancelled parity
      err_o = ECC_DOUBLE;
    end
  end

  assign data_o     = data_fix;
  assign syndrome_o = syndrome;

endmodule

/* hci_mem_intf_ecc_enc.sv */
`timescale 1ns/1ps

module hci_mem_intf_ecc_enc #(
  parameter int unsigned UW = 4
) (
  // plain request side
  input  logic                                req_i,
  output logic                                gnt_o,
  input  logic [hci_ecc_pkg::HCI_DW-1:0]      add_i,
  input  logic                                wen_i,
  input  logic [hci_ecc_pkg::HCI_DW-1:0]      data_i,
  input  logic [hci_ecc_pkg::HCI_BEW-1:0]     be_i,
  input  logic [UW-1:0]                       user_i,
  // plain response side
  output logic [hci_ecc_pkg::HCI_DW-1:0]      r_data_o,
  output logic [UW-1:0]                       r_user_o,
  output logic                                r_valid_o,
  // fault injection masks over the 39-bit codeword
  input  logic [hci_ecc_pkg::CW_BITS-1:0]     wr_flip_i,
  input  logic [hci_ecc_pkg::CW_BITS-1:0]     rd_flip_i,
  // read response check
  output logic [hci_ecc_pkg::ECC_BITS-1:0]    rd_syndrome_o,
  output hci_ecc_pkg::ecc_err_e               rd_err_o,
  // protected bus, user is UW + ECC_BITS wide
  hci_mem_intf.initiator                      bus_out
);

  import hci_ecc_pkg::*;

  localparam int unsigned ECC_UW = UW + ECC_BITS;

  logic [CW_BITS-1:0]  wr_code_clean;
  logic [CW_BITS-1:0]  wr_code;
  logic [CW_BITS-1:0]  rd_code;
  logic [ECC_BITS-1:0] rd_syndrome;
  ecc_err_e            rd_err;

  // write path, encode then corrupt for test
  secded_39_32_enc i_wr_enc (
    .data_i ( data_i        ),
    .code_o ( wr_code_clean )
  );

  assign wr_code = wr_code_clean ^ wr_flip_i;

  // request fields pass straight through
  assign bus_out.req  = req_i;
  assign bus_out.add  = add_i;
  assign bus_out.wen  = wen_i;
  assign bus_out.be   = be_i;
  assign bus_out.data = wr_code[HCI_DW-1:0];
  // check bits go on top of the payload user bits
  assign bus_out.user = {wr_code[CW_BITS-1:HCI_DW], user_i};
  assign gnt_o        = bus_out.gnt;

  // read path, rebuild the codeword from r_data and upper r_user
  assign rd_code = {bus_out.r_user[ECC_UW-1:UW], bus_out.r_data} ^ rd_flip_i;

  secded_39_32_dec i_rd_dec (
    .code_i     ( rd_code     ),
    .data_o     ( r_data_o    ),
    .syndrome_o ( rd_syndrome ),
    .err_o      ( rd_err      )
  );

  assign r_user_o  = bus_out.r_user[UW-1:0];
  assign r_valid_o = bus_out.r_valid;

  // check result only means something with a response on the bus
  assign rd_syndrome_o = bus_out.r_valid ? rd_syndrome : '0;
  assign rd_err_o      = bus_out.r_valid ? rd_err : ECC_NONE;

endmodule

/* hci_mem_intf_ecc_dec.sv */
`timescale 1ns/1ps

module hci_mem_intf_ecc_dec #(
  parameter int unsigned UW = 4
) (
  // protected side, user is UW + ECC_BITS wide
  hci_mem_intf.target                      bus_in,
  // plain side towards the memory, user is UW wide
  hci_mem_intf.initiator                   bus_out,
  // write check result
  output logic [hci_ecc_pkg::ECC_BITS-1:0] syndrome_o,
  output hci_ecc_pkg::ecc_err_e            err_o
);

  import hci_ecc_pkg::*;

  localparam int unsigned ECC_UW = UW + ECC_BITS;

  logic [CW_BITS-1:0]  req_code;
  logic [HCI_DW-1:0]   data_fix;
  logic [ECC_BITS-1:0] syndrome;
  ecc_err_e            err;
  logic [CW_BITS-1:0]  rsp_code;

  // incoming codeword, check bits sit in the upper user bits
  assign req_code = {bus_in.user[ECC_UW-1:UW], bus_in.data};

  secded_39_32_dec i_req_dec (
    .code_i     ( req_code ),
    .data_o     ( data_fix ),
    .syndrome_o ( syndrome ),
    .err_o      ( err      )
  );

  // control and address pass through untouched
  assign bus_out.req  = bus_in.req;
  assign bus_out.add  = bus_in.add;
  assign bus_out.wen  = bus_in.wen;
  assign bus_out.be   = bus_in.be;
  // memory only ever sees corrected data
  assign bus_out.data = data_fix;
  // strip the check bits
  assign bus_out.user = bus_in.user[UW-1:0];
  assign bus_in.gnt   = bus_out.gnt;

  // double errors are flagged only, the word is stored as decoded
  assign syndrome_o = bus_in.req ? syndrome : '0;
  assign err_o      = bus_in.req ? err : ECC_NONE;

  // response path, protect read data again before it leaves
  secded_39_32_enc i_rsp_enc (
    .data_i ( bus_out.r_data ),
    .code_o ( rsp_code       )
  );

  assign bus_in.r_data  = rsp_code[HCI_DW-1:0];
  assign bus_in.r_user  = {rsp_code[CW_BITS-1:HCI_DW], bus_out.r_user};
  assign bus_in.r_valid = bus_out.r_valid;

endmodule

/* hci_ecc_mem.sv */
`timescale 1ns/1ps

module hci_ecc_mem #(
  parameter int unsigned AW       = 10,
  parameter int unsigned UW       = 4,
  parameter int unsigned NumWords = 1024
) (
  input  logic       clk_i,
  input  logic       rst_i,
  hci_mem_intf.target bus
);

  import hci_ecc_pkg::*;

  // storage, no reset on the arrays
  logic [HCI_DW-1:0] data_q [NumWords];
  logic [UW-1:0]     user_q [NumWords];

  logic [AW-1:0]     idx;
  logic              accept;
  logic              gnt_q;
  logic              rvalid_q;
  logic [HCI_DW-1:0] rdata_q;
  logic [UW-1:0]     ruser_q;

  // byte address on the bus, drop the byte offset
  assign idx    = bus.add[AW+1:2];
  assign accept = bus.req & bus.gnt;

  // byte-enabled write
  always_ff @(posedge clk_i) begin
    if (accept && !bus.wen) begin
      for (int unsigned b = 0; b < HCI_BEW; b++) begin
        if (bus.be[b]) begin
          data_q[idx][8*b +: 8] <= bus.data[8*b +: 8];
        end
      end
      // user field has no byte lanes, any enabled byte writes it whole
      if (|bus.be) begin
        user_q[idx] <= bus.user;
      end
    end
  end

  // read payload, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (accept && bus.wen) begin
      rdata_q <= data_q[idx];
      ruser_q <= user_q[idx];
    end
  end

  // control state
  // grant comes up one edge after reset is released, then stays high
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      gnt_q    <= 1'b1;
      // one pulse per accepted read
      rvalid_q <= accept & bus.wen;
    end
  end

  assign bus.gnt     = gnt_q;
  assign bus.r_valid = rvalid_q;
  assign bus.r_data  = rdata_q;
  assign bus.r_user  = ruser_q;

endmodule

/* hci_ecc_top.sv */
`timescale 1ns/1ps

module hci_ecc_top #(
  parameter int unsigned AW       = 10,
  parameter int unsigned UW       = 4,
  parameter int unsigned NumWords = 1024
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // request
  input  logic                             req_i,
  output logic                             gnt_o,
  input  logic [AW-1:0]                    add_i,
  input  logic                             wen_i,
  input  logic [hci_ecc_pkg::HCI_DW-1:0]   data_i,
  input  logic [hci_ecc_pkg::HCI_BEW-1:0]  be_i,
  input  logic [UW-1:0]                    user_i,
  // response
  output logic [hci_ecc_pkg::HCI_DW-1:0]   r_data_o,
  output logic [UW-1:0]                    r_user_o,
  output logic                             r_valid_o,
  // fault injection
  input  logic [hci_ecc_pkg::CW_BITS-1:0]  wr_flip_i,
  input  logic [hci_ecc_pkg::CW_BITS-1:0]  rd_flip_i,
  // write check, seen at the memory side adapter
  output logic [hci_ecc_pkg::ECC_BITS-1:0] wr_syndrome_o,
  output hci_ecc_pkg::ecc_err_e            wr_err_o,
  // read check, seen at the initiator side adapter
  output logic [hci_ecc_pkg::ECC_BITS-1:0] rd_syndrome_o,
  output hci_ecc_pkg::ecc_err_e            rd_err_o
);

  import hci_ecc_pkg::*;

  localparam int unsigned ECC_UW = UW + ECC_BITS;

  // word index to bus byte address
  logic [HCI_DW-1:0] add_byte;

  assign add_byte = {{(HCI_DW-AW-2){1'b0}}, add_i, 2'b00};

  // protected hop and plain hop
  hci_mem_intf #(.UW(ECC_UW)) bus_ecc ();
  hci_mem_intf #(.UW(UW))     bus_mem ();

  hci_mem_intf_ecc_enc #(
    .UW ( UW )
  ) i_ecc_enc (
    .req_i         ( req_i         ),
    .gnt_o         ( gnt_o         ),
    .add_i         ( add_byte      ),
    .wen_i         ( wen_i         ),
    .data_i        ( data_i        ),
    .be_i          ( be_i          ),
    .user_i        ( user_i        ),
    .r_data_o      ( r_data_o      ),
    .r_user_o      ( r_user_o      ),
    .r_valid_o     ( r_valid_o     ),
    .wr_flip_i     ( wr_flip_i     ),
    .rd_flip_i     ( rd_flip_i     ),
    .rd_syndrome_o ( rd_syndrome_o ),
    .rd_err_o      ( rd_err_o      ),
    .bus_out       ( bus_ecc       )
  );

  hci_mem_intf_ecc_dec #(
    .UW ( UW )
  ) i_ecc_dec (
    .bus_in     ( bus_ecc       ),
    .bus_out    ( bus_mem       ),
    .syndrome_o ( wr_syndrome_o ),
    .err_o      ( wr_err_o      )
  );

  hci_ecc_mem #(
    .AW       ( AW       ),
    .UW       ( UW       ),
    .NumWords ( NumWords )
  ) i_mem (
    .clk_i ( clk_i   ),
    .rst_i ( rst_i   ),
    .bus   ( bus_mem )
  );

endmodule

/* hci_ecc_asserts.sv */
`timescale 1ns/1ps

module hci_ecc_asserts (
  input logic       clk_i,
  input logic       rst_i,
  input logic       req_i,
  input logic       gnt_i,
  input logic       wen_i,
  input logic       r_valid_i,
  input logic [1:0] wr_err_i,
  input logic [1:0] rd_err_i
);

  // failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // no response in reset or in the first cycle after it
  a_rvalid_reset: assert property (@(posedge clk_i) rst_i |=> !r_valid_i)
    else begin
      fail_count++;
      $error("r_valid high during or right after reset");
    end

  // every accepted read answers on the next edge
  a_read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i && gnt_i && wen_i) |=> r_valid_i)
    else begin
      fail_count++;
      $error("accepted read not answered one cycle later");
    end

  // and nothing else produces a response
  a_no_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_i |-> $past(req_i && gnt_i && wen_i))
    else begin
      fail_count++;
      $error("r_valid without an accepted read");
    end

  a_err_class: assert property (@(posedge clk_i) disable iff (rst_i)
    (wr_err_i != 2'd3) && (rd_err_i != 2'd3))
    else begin
      fail_count++;
      $error("error class has the unused value 3");
    end

endmodule

bind hci_ecc_top hci_ecc_asserts i_asserts (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .req_i     ( req_i     ),
  .gnt_i     ( gnt_o     ),
  .wen_i     ( wen_i     ),
  .r_valid_i ( r_valid_o ),
  .wr_err_i  ( wr_err_o  ),
  .rd_err_i  ( rd_err_o  )
);

/* tb_hci_ecc_top.sv */
`timescale 1ns/1ps

module tb_hci_ecc_top;

  import hci_ecc_pkg::*;

  localparam int unsigned AW       = 10;
  localparam int unsigned UW       = 4;
  localparam int unsigned NumWords = 1024;
  localparam int unsigned NUM_ADDR = 16;
  localparam int unsigned TIMEOUT  = 20;

  // one expected read response
  typedef struct {
    int unsigned         add;
    logic [HCI_DW-1:0]   data;
    logic [UW-1:0]       user;
    bit                  check;
    ecc_err_e            err;
    logic [ECC_BITS-1:0] syn;
  } rd_exp_t;

  logic                clk_i = 1'b0;
  logic                rst_i;
  logic                req_i;
  logic                gnt_o;
  logic [AW-1:0]       add_i;
  logic                wen_i;
  logic [HCI_DW-1:0]   data_i;
  logic [HCI_BEW-1:0]  be_i;
  logic [UW-1:0]       user_i;
  logic [HCI_DW-1:0]   r_data_o;
  logic [UW-1:0]       r_user_o;
  logic                r_valid_o;
  logic [CW_BITS-1:0]  wr_flip_i;
  logic [CW_BITS-1:0]  rd_flip_i;
  logic [ECC_BITS-1:0] wr_syndrome_o;
  ecc_err_e            wr_err_o;
  logic [ECC_BITS-1:0] rd_syndrome_o;
  ecc_err_e            rd_err_o;

  // reference model state
  logic [HCI_DW-1:0] shadow_data [NumWords];
  logic [UW-1:0]     shadow_user [NumWords];
  bit                known [NumWords];
  rd_exp_t           exp_q [$];
  int unsigned       acc_q [$];
  int unsigned       cycle = 0;
  int unsigned       addrs [NUM_ADDR];
  int unsigned       flip_bits [5] = '{0, 13, 31, 32, 38};
  int                seed = 32'h53e8_ca57;

  hci_ecc_top #(
    .AW       ( AW       ),
    .UW       ( UW       ),
    .NumWords ( NumWords )
  ) dut_i (
    .clk_i, .rst_i, .req_i, .gnt_o, .add_i, .wen_i, .data_i, .be_i, .user_i,
    .r_data_o, .r_user_o, .r_valid_o, .wr_flip_i, .rd_flip_i,
    .wr_syndrome_o, .wr_err_o, .rd_syndrome_o, .rd_err_o
  );

  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  // expected class from the number of flipped bits, syndrome from the matrix
  function automatic void ecc_expect(input logic [CW_BITS-1:0] flip,
                                     output ecc_err_e err,
                                     output logic [ECC_BITS-1:0] syn);
    int unsigned ones;
    ones = $countones(flip);
    for (int unsigned i = 0; i < ECC_BITS; i++) begin
      syn[i] = ^(flip & SECDED_H[i]);
    end
    err = (ones == 0) ? ECC_NONE : (ones == 1) ? ECC_SINGLE : ECC_DOUBLE;
  endfunction

  function automatic logic [CW_BITS-1:0] one_hot(input int unsigned pos);
    logic [CW_BITS-1:0] m;
    m      = '0;
    m[pos] = 1'b1;
    return m;
  endfunction

  task automatic check_data(input logic [HCI_DW-1:0] got_data,
                            input logic [HCI_DW-1:0] exp_data,
                            input logic [UW-1:0]     got_user,
                            input logic [UW-1:0]     exp_user,
                            input string             what);
    if (got_data !== exp_data || got_user !== exp_user) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h/%h, expected %h/%h",
                          $time, what, got_data, got_user, exp_data, exp_user));
    end
  endtask

  task automatic check_err(input ecc_err_e            got_err,
                           input ecc_err_e            exp_err,
                           input logic [ECC_BITS-1:0] got_syn,
                           input logic [ECC_BITS-1:0] exp_syn,
                           input string               what);
    if (got_err !== exp_err || got_syn !== exp_syn) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s class %0d syndrome %b, expected %0d %b",
                          $time, what, got_err, got_syn, exp_err, exp_syn));
    end
  endtask

  // response checker, outputs sampled at the rising edge
  always @(posedge clk_i) begin
    rd_exp_t     e;
    int unsigned acc;
    if (r_valid_o === 1'b1) begin
      if (exp_q.size() == 0 || acc_q.size() == 0) begin
        abort_run("a read response arrived with no read outstanding");
      end
      acc = acc_q.pop_front();
      e   = exp_q.pop_front();
      if (cycle != acc + 1) begin
        abort_run($sformatf("CHECK FAILED at %0t ns: response %0d cycles after accept",
                            $time, cycle - acc));
      end
      if (e.check) begin
        check_data(r_data_o, e.data, r_user_o, e.user, $sformatf("read of word %0d", e.add));
      end
      check_err(rd_err_o, e.err, rd_syndrome_o, e.syn, "read check");
    end else if (rst_i === 1'b0) begin
      // no response on the bus, the read check stays quiet
      check_err(rd_err_o, ECC_NONE, rd_syndrome_o, '0, "idle read check");
    end
    // write check stays quiet without a request
    if (rst_i === 1'b0 && req_i !== 1'b1) begin
      check_err(wr_err_o, ECC_NONE, wr_syndrome_o, '0, "idle write check");
    end
    // acceptance seen in this cycle
    if (req_i === 1'b1 && gnt_o === 1'b1 && wen_i === 1'b1) begin
      acc_q.push_back(cycle);
    end
    cycle++;
  end

  task automatic wait_grant();
    int unsigned n;
    n = 0;
    @(posedge clk_i);
    while (gnt_o !== 1'b1) begin
      n++;
      if (n > TIMEOUT) abort_run("timeout, the request was never granted");
      @(posedge clk_i);
    end
  endtask

  // all outstanding reads answered
  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) abort_run("timeout, no read response arrived for an outstanding read");
    end
  endtask

  task automatic write_word(input int unsigned addr, input logic [HCI_DW-1:0] data,
                            input logic [HCI_BEW-1:0] be, input logic [UW-1:0] user,
                            input logic [CW_BITS-1:0] flip);
    ecc_err_e            exp_err;
    logic [ECC_BITS-1:0] exp_syn;
    ecc_expect(flip, exp_err, exp_syn);
    @(negedge clk_i);
    req_i     = 1'b1;
    wen_i     = 1'b0;
    add_i     = AW'(addr);
    data_i    = data;
    be_i      = be;
    user_i    = user;
    wr_flip_i = flip;
    wait_grant();
    check_err(wr_err_o, exp_err, wr_syndrome_o, exp_syn, "write check");
    // a double fault leaves the stored word undefined
    if (exp_err == ECC_DOUBLE) begin
      known[addr] = 1'b0;
    end else begin
      for (int unsigned b = 0; b < HCI_BEW; b++) begin
        if (be[b]) shadow_data[addr][8*b +: 8] = data[8*b +: 8];
      end
      if (|be) shadow_user[addr] = user;
      if (be == '1) known[addr] = 1'b1;
    end
    @(negedge clk_i);
    req_i     = 1'b0;
    // the fault mask lingers for one idle cycle
    @(negedge clk_i);
    wr_flip_i = '0;
  endtask

  function automatic rd_exp_t expect_read(input int unsigned addr,
                                          input logic [CW_BITS-1:0] flip);
    rd_exp_t e;
    e.add  = addr;
    e.data = shadow_data[addr];
    e.user = shadow_user[addr];
    ecc_expect(flip, e.err, e.syn);
    e.check = known[addr] && (e.err != ECC_DOUBLE);
    return e;
  endfunction

  // rd_flip is held from the request until the response is checked
  task automatic read_word(input int unsigned addr, input logic [CW_BITS-1:0] flip);
    @(negedge clk_i);
    req_i     = 1'b1;
    wen_i     = 1'b1;
    add_i     = AW'(addr);
    be_i      = '0;
    rd_flip_i = flip;
    exp_q.push_back(expect_read(addr, flip));
    wait_grant();
    @(negedge clk_i);
    req_i     = 1'b0;
    wait_drain();
    rd_flip_i = '0;
  endtask

  // one read per cycle, no gaps
  task automatic read_burst(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk_i);
      if (gnt_o !== 1'b1) abort_run("grant dropped during a read burst");
      req_i = 1'b1;
      wen_i = 1'b1;
      add_i = AW'(addrs[i % NUM_ADDR]);
      exp_q.push_back(expect_read(addrs[i % NUM_ADDR], '0));
    end
    @(negedge clk_i);
    req_i = 1'b0;
    wait_drain();
  endtask

  initial begin
    logic [31:0] r;
    rst_i     = 1'b1;
    // a read request held through reset must not be granted
    req_i     = 1'b1;
    wen_i     = 1'b1;
    add_i     = '0;
    data_i    = '0;
    be_i      = '0;
    user_i    = '0;
    wr_flip_i = '0;
    rd_flip_i = '0;
    for (int unsigned i = 0; i < NUM_ADDR; i++) addrs[i] = (i * 97 + 3) % NumWords;
    repeat (3) begin
      @(negedge clk_i);
      if (gnt_o !== 1'b0) abort_run("the request was granted while reset was asserted");
    end
    rst_i = 1'b0;
    req_i = 1'b0;
    wait_grant();

    // clean fill, then a random mix of partial writes and reads
    for (int unsigned i = 0; i < NUM_ADDR; i++) begin
      write_word(addrs[i], $random(seed), 4'hf, UW'($random(seed)), '0);
    end
    for (int unsigned i = 0; i < 60; i++) begin
      r = $random(seed);
      if (r[0]) write_word(addrs[r[11:8]], $random(seed), r[7:4], r[15:12], '0);
      else read_word(addrs[r[11:8]], '0);
    end

    // single write faults are corrected before storage
    foreach (flip_bits[k]) begin
      write_word(addrs[k], $random(seed), 4'hf, UW'($random(seed)), one_hot(flip_bits[k]));
      read_word(addrs[k], '0);
    end

    // double write faults, then recovery by a full rewrite
    write_word(addrs[6], $random(seed), 4'hf, 4'h5, one_hot(3) | one_hot(20));
    read_word(addrs[6], '0);
    write_word(addrs[7], $random(seed), 4'h3, 4'ha, one_hot(33) | one_hot(36));
    write_word(addrs[6], $random(seed), 4'hf, 4'h9, '0);
    write_word(addrs[7], $random(seed), 4'hf, 4'h6, '0);
    read_word(addrs[6], '0);
    read_word(addrs[7], '0);

    // faults on the read path
    foreach (flip_bits[k]) read_word(addrs[8], one_hot(flip_bits[k]));
    read_word(addrs[9], one_hot(5) | one_hot(35));

    read_burst(2 * NUM_ADDR);

    if (dut_i.i_asserts.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
hci_ecc_pkg.sv
hci_mem_intf.sv
secded_39_32_enc.sv
secded_39_32_dec.sv
hci_mem_intf_ecc_enc.sv
hci_mem_intf_ecc_dec.sv
hci_ecc_mem.sv
hci_ecc_top.sv
hci_ecc_asserts.sv
tb_hci_ecc_top.sv

/* Bender.yml */
package:
  name: hci_ecc

sources:
  - hci_ecc_pkg.sv
  - hci_mem_intf.sv
  - secded_39_32_enc.sv
  - secded_39_32_dec.sv
  - hci_mem_intf_ecc_enc.sv
  - hci_mem_intf_ecc_dec.sv
  - hci_ecc_mem.sv
  - hci_ecc_top.sv
  - target: test
    files:
      - hci_ecc_asserts.sv
      - tb_hci_ecc_top.sv
